// ==== build.f ====
+incdir+verif
rtl/spim_pkg.sv
rtl/spim_sync_fifo.sv
rtl/host_access_decode.sv
rtl/spim_csr.sv
rtl/host_read_return.sv
rtl/spim_buf_top.sv
verif/spim_buf_tb.sv

// ==== verif/spim_buf_model.svh ====
`ifndef SPIM_BUF_MODEL_SVH
`define SPIM_BUF_MODEL_SVH

// reference model, every variable holds its value after the last clock edge
logic [DATA_W-1:0]    m_wq[$];     // write buffer, host to spi
logic [DATA_W-1:0]    m_rq[$];     // read buffer, spi to host
logic [ST_FLAG_W-1:0] m_flags;
cmd_word_u            m_cmd;
logic                 m_tv_d1;
logic [13:0]          m_brstlen;
logic                 m_rdnwr;
logic [1:0]           m_sselect;
logic                 m_acc_wr;    // request sitting in the access stage
logic                 m_acc_rd;
logic [ADDR_W-1:0]    m_acc_addr;
logic [DATA_W-1:0]    m_acc_wdata;
logic                 m_rd_vld_q;  // read picked up at the access edge
logic [DATA_W-1:0]    m_rd_q;
logic                 m_vld;       // what the host bus shows
logic [DATA_W-1:0]    m_rdata;

// 0 unmapped, 1 command, 2 status, 3 write window, 4 read window
function automatic int addr_kind(input logic [ADDR_W-1:0] a);
	if (a == CSR_CMD_ADDR)
		return 1;
	if (a == CSR_STATUS_ADDR)
		return 2;
	if (a >= WBUF_LO && a <= WBUF_HI)
		return 3;
	if (a >= RBUF_LO && a <= RBUF_HI)
		return 4;
	return 0;
endfunction

task automatic reset_model();
	m_wq.delete();
	m_rq.delete();
	m_flags     = '0;
	m_cmd       = '0;
	m_tv_d1     = 1'b0;
	m_brstlen   = '0;
	m_rdnwr     = 1'b0;
	m_sselect   = '0;
	m_acc_wr    = 1'b0;
	m_acc_rd    = 1'b0;
	m_acc_addr  = '0;
	m_acc_wdata = '0;
	m_rd_vld_q  = 1'b0;
	m_rd_q      = '0;
	m_vld       = 1'b0;
	m_rdata     = '0;
endtask

function automatic logic [DATA_W-1:0] expected_status();
	logic [DATA_W-1:0] s;
	s = '0;
	s[ST_FLAG_W-1:0]    = m_flags;
	s[ST_WBUF_CNT +: 8] = 8'(m_wq.size());
	s[ST_RBUF_CNT +: 8] = 8'(m_rq.size());
	return s;
endfunction

// command outputs as the spi engine should see them
function automatic cmd_word_u expected_cmd();
	cmd_word_u c;
	c = '0;
	c.f.sselect  = m_sselect;
	c.f.brstlen  = m_brstlen;
	c.f.rdnwr    = m_rdnwr;
	c.f.transvld = m_cmd.f.transvld; // no extra delay
	return c;
endfunction

// one clock edge, using the inputs driven in the cycle before it
task automatic advance_model();
	int                   kind;
	int                   w_size;
	int                   r_size;
	logic [DATA_W-1:0]    sel;
	logic [ST_FLAG_W-1:0] flag_set;
	logic [ST_FLAG_W-1:0] flag_clr;
	kind     = addr_kind(m_acc_addr);
	w_size   = m_wq.size();
	r_size   = m_rq.size();
	flag_set = '0;
	flag_clr = '0;
	case (kind)   // read source is the state before this edge
		1:       sel = m_cmd.raw;
		2:       sel = expected_status();
		4:       sel = (r_size > 0) ? m_rq[0] : '0;
		default: sel = '0;
	endcase
	if (m_rd_vld_q)
		m_rdata = m_rd_q;
	m_vld = m_rd_vld_q;
	if (m_acc_rd)
		m_rd_q = sel;
	m_rd_vld_q = m_acc_rd;

	// write buffer, host pushes and spi pops
	if (spi_read && w_size == 0)
		flag_set[ST_WBUF_UDF] = 1'b1;
	if (m_acc_wr && kind == 3 && w_size == TB_DEPTH)
		flag_set[ST_WBUF_OVF] = 1'b1;
	if (spi_read && w_size > 0)
		void'(m_wq.pop_front());
	if (m_acc_wr && kind == 3 && w_size < TB_DEPTH)
		m_wq.push_back(m_acc_wdata);

	if (ssn_on_pulse) begin
		m_rq.delete(); // flush beats push and pop
	end else begin
		if (m_acc_rd && kind == 4 && r_size == 0)
			flag_set[ST_RBUF_UDF] = 1'b1;
		if (spi_write && r_size == TB_DEPTH)
			flag_set[ST_RBUF_OVF] = 1'b1;
		if (m_acc_rd && kind == 4 && r_size > 0)
			void'(m_rq.pop_front());
		if (spi_write && r_size < TB_DEPTH)
			m_rq.push_back(miso_data);
	end

	if (m_acc_wr && kind == 2)
		flag_clr = m_acc_wdata[ST_FLAG_W-1:0];
	m_flags = (m_flags & ~flag_clr) | flag_set;

	if (m_cmd.f.transvld && !m_tv_d1) begin   // load on the rising edge of transfer valid
		m_brstlen = m_cmd.f.brstlen;
		m_rdnwr   = m_cmd.f.rdnwr;
		m_sselect = m_cmd.f.sselect;
	end
	m_tv_d1 = m_cmd.f.transvld;
	if (m_acc_wr && kind == 1)
		m_cmd.raw = m_acc_wdata;
	else if (stransvld_up)
		m_cmd.f.transvld = 1'b0;

	m_acc_wr   = host_write;
	m_acc_rd   = host_read;
	m_acc_addr = host_addr;
	if (host_write)
		m_acc_wdata = host_wdata;
endtask

`endif

// ==== verif/spim_buf_tb.sv ====
`timescale 1ns/1ps

module spim_buf_tb import spim_pkg::*; ();

	localparam int TB_DEPTH        = 16;                 // small buffers fill quickly
	localparam int RESET_CYCLES    = 10;
	localparam int DIRECTED_CYCLES = 4 * TB_DEPTH + 100; // overfill phases dominate
	localparam int RAND_CYCLES     = 3000;
	localparam int CYCLE_LIMIT     = RESET_CYCLES + DIRECTED_CYCLES + RAND_CYCLES + 200;

	logic              sclk_in;
	logic              rst_n;
	logic              host_write;
	logic              host_read;
	logic [ADDR_W-1:0] host_addr;
	logic [DATA_W-1:0] host_wdata;
	logic [DATA_W-1:0] host_rdata;
	logic              host_rdatavld;
	logic              spi_write;
	logic              spi_read;
	logic [DATA_W-1:0] miso_data;
	logic [DATA_W-1:0] mosi_data;
	logic              ssn_on_pulse;
	logic              stransvld_up;
	logic              s_transvld;
	logic [13:0]       spim_brstlen;
	logic              spim_rdnwr;
	logic [1:0]        spim_sselect;
	int                mismatches;
	int                failures;
	int                cycles;

	`include "spim_buf_model.svh"

	spim_buf_top #(.FIFO_DEPTH(TB_DEPTH), .FIFO_WIDTH(DATA_W)) DUT (
		.sclk_in       (sclk_in),
		.rst_n         (rst_n),
		.host_write    (host_write),
		.host_read     (host_read),
		.host_addr     (host_addr),
		.host_wdata    (host_wdata),
		.host_rdata    (host_rdata),
		.host_rdatavld (host_rdatavld),
		.spi_write     (spi_write),
		.spi_read      (spi_read),
		.miso_data     (miso_data),
		.mosi_data     (mosi_data),
		.ssn_on_pulse  (ssn_on_pulse),
		.stransvld_up  (stransvld_up),
		.s_transvld    (s_transvld),
		.spim_brstlen  (spim_brstlen),
		.spim_rdnwr    (spim_rdnwr),
		.spim_sselect  (spim_sselect)
	);

	always #2 sclk_in = ~sclk_in; // 4 ns period

	always @(posedge sclk_in) begin
		cycles = cycles + 1;
		if (cycles > CYCLE_LIMIT) begin
			failures++;
			$display("timeout, the run did not finish within %0d cycles", CYCLE_LIMIT);
			$display("errors: %0d mismatches, %0d other failures", mismatches, failures);
			$display("Test failures found");
			$finish;
		end
	end

	////////////////////////////////////////
	// compare tasks
	////////////////////////////////////////
	task automatic check_word(input logic [DATA_W-1:0] act, input logic [DATA_W-1:0] exp,
			input string what);
		if (act !== exp) begin
			mismatches++;
			$display("mismatch at %0t: %s expected %h, got %h", $time, what, exp, act);
		end
	endtask

	task automatic check_bit(input logic act, input logic exp, input string what);
		if (act !== exp) begin
			mismatches++;
			$display("mismatch at %0t: %s expected %b, got %b", $time, what, exp, act);
		end
	endtask

	// reserved bits carry nothing to the spi engine
	task automatic check_cmd(input cmd_word_u act, input cmd_word_u exp, input string what);
		string exp_s;
		string act_s;
		if (act.f.sselect !== exp.f.sselect || act.f.brstlen !== exp.f.brstlen ||
				act.f.rdnwr !== exp.f.rdnwr || act.f.transvld !== exp.f.transvld) begin
			mismatches++;
			exp_s = $sformatf("sel %h len %h rdnwr %b vld %b",
				exp.f.sselect, exp.f.brstlen, exp.f.rdnwr, exp.f.transvld);
			act_s = $sformatf("sel %h len %h rdnwr %b vld %b",
				act.f.sselect, act.f.brstlen, act.f.rdnwr, act.f.transvld);
			$display("mismatch at %0t: %s expected %s, got %s", $time, what, exp_s, act_s);
		end
	endtask

	function automatic cmd_word_u cmd_outputs();
		cmd_word_u c;
		c = '0;
		c.f.sselect  = spim_sselect;
		c.f.brstlen  = spim_brstlen;
		c.f.rdnwr    = spim_rdnwr;
		c.f.transvld = s_transvld;
		return c;
	endfunction

	////////////////////////////////////////
	// stimulus
	////////////////////////////////////////
	task automatic clear_inputs();
		host_write   = 1'b0;
		host_read    = 1'b0;
		host_addr    = '0;
		host_wdata   = '0;
		spi_write    = 1'b0;
		spi_read     = 1'b0;
		miso_data    = '0;
		ssn_on_pulse = 1'b0;
		stransvld_up = 1'b0;
	endtask

	// check mid cycle while the inputs hold and move on to the next drive point
	task automatic tick();
		logic [DATA_W-1:0] exp_mosi;
		@(negedge sclk_in);
		exp_mosi = (spi_read && m_wq.size() > 0) ? m_wq[0] : '0;
		check_bit(host_rdatavld, m_vld, "host_rdatavld");
		if (m_vld)
			check_word(host_rdata, m_rdata, "host_rdata");
		check_word(mosi_data, exp_mosi, "mosi_data");
		check_cmd(cmd_outputs(), expected_cmd(), "command outputs");
		advance_model();
		@(posedge sclk_in);
		#1;
		clear_inputs();
	endtask

	task automatic idle(input int n);
		repeat (n) tick();
	endtask

	task automatic host_wr(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data);
		host_write = 1'b1;
		host_addr  = addr;
		host_wdata = data;
		tick();
	endtask

	task automatic host_rd(input logic [ADDR_W-1:0] addr);
		host_read = 1'b1;
		host_addr = addr;
		tick();
	endtask

	task automatic spi_push(input logic [DATA_W-1:0] data);
		spi_write = 1'b1;
		miso_data = data;
		tick();
	endtask

	task automatic spi_pop();
		spi_read = 1'b1;
		tick();
	endtask

	task automatic random_inputs();
		int   op;
		logic coin;
		op         = $urandom % 16; // 0 to 4 leave the host bus idle
		coin       = $urandom % 2;
		host_wdata = $urandom;
		case (op)
			5, 6, 7:  host_addr = WBUF_LO + ADDR_W'($urandom % 32'h800);
			8, 9, 10: host_addr = RBUF_LO + ADDR_W'($urandom % 32'h800);
			11, 12:   host_addr = CSR_STATUS_ADDR;
			13, 14:   host_addr = CSR_CMD_ADDR;
			default:  host_addr = ADDR_W'($urandom);
		endcase
		host_write   = (op >= 5 && op <= 7) || op == 12 || op == 13 || (op == 15 && coin);
		host_read    = (op >= 8 && op <= 11) || op == 14 || (op == 15 && !coin);
		spi_write    = ($urandom % 4 == 0);
		miso_data    = $urandom;
		spi_read     = ($urandom % 4 == 0);
		ssn_on_pulse = ($urandom % 64 == 0);
		// never retire a transfer while a command write starts one
		stransvld_up = ($urandom % 8 == 0) &&
			!(m_acc_wr && addr_kind(m_acc_addr) == 1 && m_acc_wdata[0]);
	endtask

	initial begin : main_seq
		logic [DATA_W-1:0] word;
		int                i;
		void'($urandom(32'hc685_9a6d));
		mismatches = 0;
		failures   = 0;
		cycles     = 0;
		sclk_in    = 1'b0;
		rst_n      = 1'b0;
		clear_inputs();
		reset_model();
		repeat (RESET_CYCLES) @(posedge sclk_in);
		#1;
		rst_n = 1'b1;

		// host fills the write buffer and spi drains it in order
		for (i = 0; i < 6; i++)
			host_wr(WBUF_LO + ADDR_W'(4 * i), $urandom);
		idle(2);
		repeat (6) spi_pop();

		// spi fills the read buffer and the host drains it
		repeat (6) spi_push($urandom);
		for (i = 0; i < 6; i++)
			host_rd(RBUF_LO + ADDR_W'(4 * i));
		idle(3);

		// command load and retire from the spi side
		word = $urandom | 32'h1;
		host_wr(CSR_CMD_ADDR, word);
		idle(3);
		check_cmd(cmd_outputs(), cmd_word_u'(word), "loaded command");
		stransvld_up = 1'b1;
		tick();
		check_bit(s_transvld, 1'b0, "s_transvld after stransvld_up");
		idle(1);
		host_rd(CSR_CMD_ADDR);
		idle(3);

		////////////////////////////////////////
		// overflow, underflow and fill counts
		////////////////////////////////////////
		repeat (TB_DEPTH + 2) host_wr(WBUF_LO, $urandom);
		idle(2);
		host_rd(CSR_STATUS_ADDR);
		idle(3);
		repeat (TB_DEPTH + 1) spi_pop();
		repeat (TB_DEPTH + 2) spi_push($urandom);
		idle(1);
		host_rd(CSR_STATUS_ADDR);
		idle(2);
		repeat (TB_DEPTH + 1) host_rd(RBUF_LO);
		idle(2);
		host_rd(CSR_STATUS_ADDR);
		idle(3);
		host_wr(CSR_STATUS_ADDR, 32'hf);
		idle(2);
		host_rd(CSR_STATUS_ADDR);
		idle(3);

		// chip select on empties the read buffer
		repeat (4) spi_push($urandom);
		ssn_on_pulse = 1'b1;
		tick();
		host_rd(RBUF_LO);
		idle(3);
		host_rd(CSR_STATUS_ADDR);
		idle(3);

		repeat (RAND_CYCLES) begin
			random_inputs();
			tick();
		end
		idle(4); // let the last reads come back

		$display("errors: %0d mismatches, %0d other failures", mismatches, failures);
		if (mismatches == 0 && failures == 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

endmodule

// ==== rtl/spim_buf_top.sv ====
`timescale 1ns/1ps

module spim_buf_top import spim_pkg::*; #(
	parameter int FIFO_DEPTH = 64,
	parameter int FIFO_WIDTH = 32
) (
	input  logic                  sclk_in,
	input  logic                  rst_n,
	// host bus
	input  logic                  host_write,
	input  logic                  host_read,
	input  logic [ADDR_W-1:0]     host_addr,
	input  logic [DATA_W-1:0]     host_wdata,
	output logic [DATA_W-1:0]     host_rdata,
	output logic                  host_rdatavld,
	// spi side
	input  logic                  spi_write,
	input  logic                  spi_read,
	input  logic [FIFO_WIDTH-1:0] miso_data,
	output logic [FIFO_WIDTH-1:0] mosi_data,
	input  logic                  ssn_on_pulse,
	input  logic                  stransvld_up,
	// command outputs
	output logic                  s_transvld,
	output logic [13:0]           spim_brstlen,
	output logic                  spim_rdnwr,
	output logic [1:0]            spim_sselect
);

	logic              acc_write;
	logic              acc_read;
	logic              hit_cmd;
	logic              hit_status;
	logic              hit_wbuf;
	logic              hit_rbuf;
	logic [DATA_W-1:0] acc_wdata;
	cmd_word_u         cmd_word;
	logic [DATA_W-1:0] status_word;
	logic [DATA_W-1:0] rbuf_rddata;
	logic              rbuf_pop;

	////////////////////////////////////////
	// stage 1, request capture
	////////////////////////////////////////
	host_access_decode u_decode (
		.sclk_in    (sclk_in),
		.rst_n      (rst_n),
		.host_write (host_write),
		.host_read  (host_read),
		.host_addr  (host_addr),
		.host_wdata (host_wdata),
		.acc_write  (acc_write),
		.acc_read   (acc_read),
		.hit_cmd    (hit_cmd),
		.hit_status (hit_status),
		.hit_wbuf   (hit_wbuf),
		.hit_rbuf   (hit_rbuf),
		.acc_wdata  (acc_wdata)
	);

	////////////////////////////////////////
	// stage 2, registers and buffers
	////////////////////////////////////////
	spim_csr #(.FIFO_DEPTH(FIFO_DEPTH), .FIFO_WIDTH(FIFO_WIDTH)) u_csr (
		.sclk_in      (sclk_in),
		.rst_n        (rst_n),
		.acc_write    (acc_write),
		.acc_read     (acc_read),
		.hit_cmd      (hit_cmd),
		.hit_status   (hit_status),
		.hit_wbuf     (hit_wbuf),
		.hit_rbuf     (hit_rbuf),
		.acc_wdata    (acc_wdata),
		.spi_write    (spi_write),
		.spi_read     (spi_read),
		.miso_data    (miso_data),
		.ssn_on_pulse (ssn_on_pulse),
		.stransvld_up (stransvld_up),
		.cmd_word     (cmd_word),
		.status_word  (status_word),
		.rbuf_rddata  (rbuf_rddata),
		.rbuf_pop     (rbuf_pop),
		.mosi_data    (mosi_data),
		.s_transvld   (s_transvld),
		.spim_brstlen (spim_brstlen),
		.spim_rdnwr   (spim_rdnwr),
		.spim_sselect (spim_sselect)
	);

	// stage 3, read data back to the host
	host_read_return u_return (
		.sclk_in       (sclk_in),
		.rst_n         (rst_n),
		.acc_read      (acc_read),
		.hit_cmd       (hit_cmd),
		.hit_status    (hit_status),
		.hit_rbuf      (hit_rbuf),
		.cmd_word      (cmd_word),
		.status_word   (status_word),
		.rbuf_rddata   (rbuf_rddata),
		.rbuf_pop      (rbuf_pop),
		.host_rdata    (host_rdata),
		.host_rdatavld (host_rdatavld)
	);

endmodule

// ==== rtl/host_read_return.sv ====
`timescale 1ns/1ps

module host_read_return import spim_pkg::*; (
	input  logic              sclk_in,
	input  logic              rst_n,
	input  logic              acc_read,
	input  logic              hit_cmd,
	input  logic              hit_status,
	input  logic              hit_rbuf,
	input  cmd_word_u         cmd_word,
	input  logic [DATA_W-1:0] status_word,
	input  logic [DATA_W-1:0] rbuf_rddata,
	input  logic              rbuf_pop,
	output logic [DATA_W-1:0] host_rdata,
	output logic              host_rdatavld
);

	logic [DATA_W-1:0] rd_sel;
	logic [DATA_W-1:0] rd_data_q;
	logic              rd_vld_q;

	// write buffer window and unmapped reads fall through to zero
	always_comb begin
		rd_sel = '0;
		if (hit_rbuf && rbuf_pop) begin
			rd_sel = rbuf_rddata; // zero already when the buffer was empty
		end else if (hit_cmd) begin
			rd_sel = cmd_word.raw;
		end else if (hit_status) begin
			rd_sel = status_word;
		end
	end

	////////////////////////////////////////
	// access capture, then return
	////////////////////////////////////////
	always_ff @(posedge sclk_in or negedge rst_n) begin
		if (!rst_n) begin
			rd_vld_q      <= 1'b0;
			host_rdatavld <= 1'b0;
		end else begin
			rd_vld_q      <= acc_read;
			host_rdatavld <= rd_vld_q; // one pulse per read
		end
	end

	always_ff @(posedge sclk_in) begin
		if (acc_read) begin
			rd_data_q <= rd_sel; // sampled on the same edge as the pop
		end
		if (rd_vld_q) begin
			host_rdata <= rd_data_q;
		end
	end

endmodule

// ==== rtl/spim_csr.sv ====
`timescale 1ns/1ps

module spim_csr import spim_pkg::*; #(
	parameter int FIFO_DEPTH = 64,
	parameter int FIFO_WIDTH = 32
) (
	input  logic                  sclk_in,
	input  logic                  rst_n,
	input  logic                  acc_write,
	input  logic                  acc_read,
	input  logic                  hit_cmd,
	input  logic                  hit_status,
	input  logic                  hit_wbuf,
	input  logic                  hit_rbuf,
	input  logic [DATA_W-1:0]     acc_wdata,
	input  logic                  spi_write,
	input  logic                  spi_read,
	input  logic [FIFO_WIDTH-1:0] miso_data,
	input  logic                  ssn_on_pulse,
	input  logic                  stransvld_up,
	output cmd_word_u             cmd_word,
	output logic [DATA_W-1:0]     status_word,
	output logic [DATA_W-1:0]     rbuf_rddata,
	output logic                  rbuf_pop,
	output logic [FIFO_WIDTH-1:0] mosi_data,
	output logic                  s_transvld,
	output logic [13:0]           spim_brstlen,
	output logic                  spim_rdnwr,
	output logic [1:0]            spim_sselect
);

	localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

	logic                  cmd_wr;
	logic                  status_wr;
	logic                  wbuf_push;
	logic [FIFO_WIDTH-1:0] wbuf_head;
	logic [FIFO_WIDTH-1:0] rbuf_head;
	logic [CNT_W-1:0]      wbuf_count;
	logic [CNT_W-1:0]      rbuf_count;
	logic                  wbuf_ovf_pulse;
	logic                  wbuf_udf_pulse;
	logic                  rbuf_ovf_pulse;
	logic                  rbuf_udf_pulse;
	logic [ST_FLAG_W-1:0]  flag_set;
	logic [ST_FLAG_W-1:0]  flag_clr;
	logic [ST_FLAG_W-1:0]  flags;
	logic                  transvld_d1;
	logic                  transvld_rise;
	cmd_word_u             wr_cmd;

	assign cmd_wr    = acc_write & hit_cmd;
	assign status_wr = acc_write & hit_status;
	assign wbuf_push = acc_write & hit_wbuf;
	assign rbuf_pop  = acc_read & hit_rbuf;

	////////////////////////////////////////
	// buffers
	////////////////////////////////////////
	spim_sync_fifo #(.FIFO_DEPTH(FIFO_DEPTH), .FIFO_WIDTH(FIFO_WIDTH)) u_wbuf (
		.sclk_in         (sclk_in),
		.rst_n           (rst_n),
		.push            (wbuf_push),
		.pop             (spi_read),   // spi always pops the write buffer
		.flush           (1'b0),
		.wrdata          (FIFO_WIDTH'(acc_wdata)),
		.rddata          (wbuf_head),
		.count           (wbuf_count),
		.overflow_pulse  (wbuf_ovf_pulse),
		.underflow_pulse (wbuf_udf_pulse)
	);

	spim_sync_fifo #(.FIFO_DEPTH(FIFO_DEPTH), .FIFO_WIDTH(FIFO_WIDTH)) u_rbuf (
		.sclk_in         (sclk_in),
		.rst_n           (rst_n),
		.push            (spi_write),
		.pop             (rbuf_pop),
		.flush           (ssn_on_pulse), // new chip select drops stale read data
		.wrdata          (miso_data),
		.rddata          (rbuf_head),
		.count           (rbuf_count),
		.overflow_pulse  (rbuf_ovf_pulse),
		.underflow_pulse (rbuf_udf_pulse)
	);

	// an empty buffer hands out zero
	assign mosi_data   = (spi_read && wbuf_count != '0) ? wbuf_head : '0;
	assign rbuf_rddata = (rbuf_count != '0) ? DATA_W'(rbuf_head) : '0;

	////////////////////////////////////////
	// sticky flags and status
	////////////////////////////////////////
	always_comb begin
		flag_set = '0;
		flag_set[ST_WBUF_OVF] = wbuf_ovf_pulse;
		flag_set[ST_WBUF_UDF] = wbuf_udf_pulse;
		flag_set[ST_RBUF_OVF] = rbuf_ovf_pulse;
		flag_set[ST_RBUF_UDF] = rbuf_udf_pulse;
	end

	assign flag_clr = status_wr ? acc_wdata[ST_FLAG_W-1:0] : '0; // write one to clear

	always_ff @(posedge sclk_in or negedge rst_n) begin
		if (!rst_n) begin
			flags <= '0;
		end else begin
			flags <= (flags & ~flag_clr) | flag_set; // a new error beats the clear
		end
	end

	always_comb begin
		status_word = '0;
		status_word[ST_FLAG_W-1:0]         = flags;
		status_word[ST_WBUF_CNT +: CNT_W] = wbuf_count;
		status_word[ST_RBUF_CNT +: CNT_W] = rbuf_count;
	end

	////////////////////////////////////////
	// command register
	////////////////////////////////////////
	always_ff @(posedge sclk_in or negedge rst_n) begin
		if (!rst_n) begin
			cmd_word <= '0;
		end else if (cmd_wr) begin
			cmd_word.raw <= acc_wdata;
		end else if (stransvld_up) begin
			cmd_word.f.transvld <= 1'b0; // spi engine took the transfer
		end
	end

	assign s_transvld    = cmd_word.f.transvld;
	assign transvld_rise = cmd_word.f.transvld & ~transvld_d1;

	always_ff @(posedge sclk_in or negedge rst_n) begin
		if (!rst_n) begin
			transvld_d1  <= 1'b0;
			spim_brstlen <= '0;
			spim_rdnwr   <= 1'b0;
			spim_sselect <= '0;
		end else begin
			transvld_d1 <= cmd_word.f.transvld;
			if (transvld_rise) begin
				spim_brstlen <= cmd_word.f.brstlen;
				spim_rdnwr   <= cmd_word.f.rdnwr;
				spim_sselect <= cmd_word.f.sselect;
			end
		end
	end

	assign wr_cmd = acc_wdata; // command word as the host writes it

	// spi side must not retire a transfer while the host starts one
	a_no_start_on_clear: assert property (
		@(posedge sclk_in) disable iff (!rst_n)
		!(stransvld_up && cmd_wr && wr_cmd.f.transvld)
	) else $error("stransvld_up collides with command write");

endmodule

// ==== rtl/host_access_decode.sv ====
`timescale 1ns/1ps

module host_access_decode import spim_pkg::*; (
	input  logic              sclk_in,
	input  logic              rst_n,
	input  logic              host_write,
	input  logic              host_read,
	input  logic [ADDR_W-1:0] host_addr,
	input  logic [DATA_W-1:0] host_wdata,
	output logic              acc_write,
	output logic              acc_read,
	output logic              hit_cmd,
	output logic              hit_status,
	output logic              hit_wbuf,
	output logic              hit_rbuf,
	output logic [DATA_W-1:0] acc_wdata
);

	logic req;
	logic dec_cmd;
	logic dec_status;
	logic dec_wbuf;
	logic dec_rbuf;

	assign req = host_write | host_read;

	////////////////////////////////////////
	// address classification
	////////////////////////////////////////
	assign dec_cmd    = (host_addr == CSR_CMD_ADDR);
	assign dec_status = (host_addr == CSR_STATUS_ADDR);
	assign dec_wbuf   = (host_addr >= WBUF_LO) && (host_addr <= WBUF_HI);
	assign dec_rbuf   = (host_addr >= RBUF_LO) && (host_addr <= RBUF_HI);

	// one request per cycle, hits only for a live strobe
	always_ff @(posedge sclk_in or negedge rst_n) begin
		if (!rst_n) begin
			acc_write  <= 1'b0;
			acc_read   <= 1'b0;
			hit_cmd    <= 1'b0;
			hit_status <= 1'b0;
			hit_wbuf   <= 1'b0;
			hit_rbuf   <= 1'b0;
		end else begin
			acc_write  <= host_write;
			acc_read   <= host_read;
			hit_cmd    <= req & dec_cmd;
			hit_status <= req & dec_status;
			hit_wbuf   <= req & dec_wbuf;
			hit_rbuf   <= req & dec_rbuf;
		end
	end

	always_ff @(posedge sclk_in) begin
		if (host_write) begin
			acc_wdata <= host_wdata; // payload only
		end
	end

	// the windows and register addresses must never overlap
	a_hit_onehot: assert property (
		@(posedge sclk_in) disable iff (!rst_n)
		(acc_write | acc_read) |-> $onehot0({hit_cmd, hit_status, hit_wbuf, hit_rbuf})
	) else $error("more than one address hit");

endmodule

// ==== rtl/spim_sync_fifo.sv ====
`timescale 1ns/1ps

module spim_sync_fifo #(
	parameter int FIFO_DEPTH = 64,
	parameter int FIFO_WIDTH = 32
) (
	input  logic                             sclk_in,
	input  logic                             rst_n,
	input  logic                             push,
	input  logic                             pop,
	input  logic                             flush,
	input  logic [FIFO_WIDTH-1:0]            wrdata,
	output logic [FIFO_WIDTH-1:0]            rddata,
	output logic [$clog2(FIFO_DEPTH+1)-1:0]  count,
	output logic                             overflow_pulse,
	output logic                             underflow_pulse
);

	localparam int CNT_W = $clog2(FIFO_DEPTH + 1);
	localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
	localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(FIFO_DEPTH - 1);

	logic [FIFO_WIDTH-1:0] mem [FIFO_DEPTH];
	logic [PTR_W-1:0]      wr_ptr;
	logic [PTR_W-1:0]      rd_ptr;
	logic                  full;
	logic                  empty;
	logic                  push_ok;
	logic                  pop_ok;

	assign full  = (count == CNT_W'(FIFO_DEPTH));
	assign empty = (count == '0);

	// flush takes the whole cycle, a push or pop next to it is lost
	assign push_ok = push & ~full & ~flush;
	assign pop_ok  = pop & ~empty & ~flush;

	assign overflow_pulse  = push & full & ~flush;
	assign underflow_pulse = pop & empty & ~flush;

	assign rddata = mem[rd_ptr]; // show-ahead head word

	////////////////////////////////////////
	// storage
	////////////////////////////////////////
	always_ff @(posedge sclk_in) begin
		if (push_ok) begin
			mem[wr_ptr] <= wrdata;
		end
	end

	////////////////////////////////////////
	// pointers and fill count
	////////////////////////////////////////
	always_ff @(posedge sclk_in or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else if (flush) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push_ok) begin
				wr_ptr <= (wr_ptr == LAST_PTR) ? '0 : wr_ptr + 1'b1; // wrap for any depth
			end
			if (pop_ok) begin
				rd_ptr <= (rd_ptr == LAST_PTR) ? '0 : rd_ptr + 1'b1;
			end
			case ({push_ok, pop_ok})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count; // idle, or push and pop together
			endcase
		end
	end

	// count tracks the pointer distance, it must stay within depth
	a_count_in_range: assert property (
		@(posedge sclk_in) disable iff (!rst_n)
		count <= CNT_W'(FIFO_DEPTH)
	) else $error("fifo count above depth");

endmodule

// ==== rtl/spim_pkg.sv ====
package spim_pkg;

	////////////////////////////////////////
	// widths
	////////////////////////////////////////
	localparam int DATA_W = 32; // host data word
	localparam int ADDR_W = 16; // host byte address

	////////////////////////////////////////
	// host address map
	////////////////////////////////////////
	localparam logic [ADDR_W-1:0] CSR_CMD_ADDR    = 16'h0000;
	localparam logic [ADDR_W-1:0] CSR_STATUS_ADDR = 16'h0004;

	localparam logic [ADDR_W-1:0] WBUF_LO = 16'h0200; // host push window
	localparam logic [ADDR_W-1:0] WBUF_HI = 16'h09FF;
	localparam logic [ADDR_W-1:0] RBUF_LO = 16'h1000; // host pop window
	localparam logic [ADDR_W-1:0] RBUF_HI = 16'h17FF;

	////////////////////////////////////////
	// status register fields
	////////////////////////////////////////
	localparam int ST_WBUF_OVF = 0;
	localparam int ST_WBUF_UDF = 1;
	localparam int ST_RBUF_OVF = 2;
	localparam int ST_RBUF_UDF = 3;
	localparam int ST_FLAG_W   = 4;  // sticky flags sit in the low bits
	localparam int ST_WBUF_CNT = 8;  // write buffer fill count lsb
	localparam int ST_RBUF_CNT = 16; // read buffer fill count lsb

	// command word, written and read back raw by the host,
	// taken apart field by field for the spi engine
	typedef union packed {
		logic [DATA_W-1:0] raw;
		struct packed {
			logic [1:0]  sselect;  // slave select
			logic [13:0] rsvd;
			logic [13:0] brstlen;  // burst length
			logic        rdnwr;    // 1 = read from slave
			logic        transvld; // transfer valid
		} f;
	} cmd_word_u;

endpackage
